// File: dv/u2_ctrl_tb.sv
`timescale 1ns/100ps
// Testbench for the housekeeping control core
// Drives Wishbone accesses and checks control lines, LEDs, readback and interrupts

module u2_ctrl_tb
   import u2_ctrl_pkg::*;
();

   localparam int DRV_DLY     = 1;
   localparam int ACK_TIMEOUT = 20;
   localparam int ONETIME_N   = 40;
   localparam int PERIOD_P    = 20;

   logic        wb_clk;
   logic        wb_rst;
   wb_adr_t     wb_adr_i;
   wb_dat_t     wb_dat_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   logic        wb_ack_o;
   wb_dat_t     wb_dat_o;
   hw_status_t  hw_status_i;
   logic        phy_int_n_i;
   logic        sim_mode_i;
   logic [3:0]  clock_divider_i;
   ctrl_lines_t ctrl_o;
   led_t        leds_o;
   logic        int_o;

   int          errors;
   int          checks;
   int unsigned tb_cycle = 0;
   logic [31:0] rng;
   // Expected contents of the setting registers
   logic [4:0]  clock_sh;
   logic [3:0]  serdes_sh;
   logic [3:0]  adc_sh;
   logic        phy_sh;
   led_t        led_src_sh;
   led_t        led_sw_sh;

   u2_ctrl_core i_dut (.*);

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   // Cycle count for the polling timeouts
   always @(posedge wb_clk) tb_cycle <= tb_cycle + 1;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic wb_adr_t bus_addr(input logic [1:0] region, input logic [7:0] idx);
      return wb_adr_t'({region, idx, 2'b00});
   endfunction

   // Fields in declaration order with the PHY pin inverted
   function automatic ctrl_lines_t ctrl_ref(input logic [4:0] clk_w, input logic [3:0] ser_w,
                                            input logic [3:0] adc_w, input logic phy_w);
      return {clk_w, ser_w, adc_w, ~phy_w};
   endfunction

   // Source bit 1 takes the hardware LED and 0 the software LED
   function automatic led_t led_ref(input led_t src, input led_t sw, input hw_status_t hw);
      led_t hw_leds;
      led_t res;
      hw_leds    = '0;
      hw_leds[4] = hw.run_tx;
      hw_leds[3] = hw.run_rx;
      hw_leds[2] = hw.clk_status;
      hw_leds[1] = hw.serdes_link_up;
      for (int i = 0; i < 8; i++) begin
         res[i] = src[i] ? hw_leds[i] : sw[i];
      end
      return res;
   endfunction

   // Sim mode flag sits in bit 31 and the divider in bits 3:0
   function automatic wb_dat_t status_ref(input logic sim, input logic [3:0] div);
      wb_dat_t w;
      w      = '0;
      w[31]  = sim;
      w[3:0] = div;
      return w;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks enter and leave DRV_DLY after a rising edge
   task automatic bus_access(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
                             output wb_dat_t rdat);
      int waited;
      waited   = 0;
      rdat     = '0;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      wb_we_i  = we;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      do begin
         @(posedge wb_clk);
         #DRV_DLY;
         waited++;
      end while (!wb_ack_o && waited < ACK_TIMEOUT);
      if (!wb_ack_o) begin
         errors++;
         $display("no ack for access to address %h within %0d cycles", adr, ACK_TIMEOUT);
      end else begin
         check_val("ack latency", waited, 1);
         rdat = wb_dat_o;
      end
      // Hold the request through the ack edge
      @(posedge wb_clk);
      #DRV_DLY;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic setting_write(input set_addr_t sa, input wb_dat_t d);
      wb_dat_t unused;
      bus_access(bus_addr(REGION_SETTINGS, sa), 1'b1, d, unused);
   endtask

   task automatic pic_write(input logic [2:0] idx, input wb_dat_t d);
      wb_dat_t unused;
      bus_access(bus_addr(REGION_PIC, {5'd0, idx}), 1'b1, d, unused);
   endtask

   task automatic word_read(input logic [1:0] region, input logic [2:0] idx, output wb_dat_t d);
      bus_access(bus_addr(region, {5'd0, idx}), 1'b0, '0, d);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge wb_clk);
      #DRV_DLY;
   endtask

   // Poll the pending word until a bit sets or the limit runs out
   task automatic wait_pending(input int bit_pos, input int limit);
      int unsigned start;
      wb_dat_t     d;
      start = tb_cycle;
      d     = '0;
      while (!d[bit_pos] && (tb_cycle - start) <= limit) begin
         word_read(REGION_PIC, 3'd1, d);
      end
      if (!d[bit_pos]) begin
         errors++;
         $display("pending bit %0d not set within %0d cycles", bit_pos, limit);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   initial begin
      wb_dat_t   rd;
      wb_dat_t   rd2;
      set_addr_t sa;
      errors          = 0;
      checks          = 0;
      rng             = 32'h647562f3;
      wb_rst          = 1'b1;
      wb_adr_i        = '0;
      wb_dat_i        = '0;
      wb_we_i         = 1'b0;
      wb_stb_i        = 1'b0;
      wb_cyc_i        = 1'b0;
      rng             = xorshift(rng);
      hw_status_i     = rng[3:0];
      phy_int_n_i     = 1'b1;
      sim_mode_i      = 1'b1;
      clock_divider_i = 4'd6;
      clock_sh        = '0;
      serdes_sh       = '0;
      adc_sh          = '0;
      phy_sh          = 1'b1;
      led_src_sh      = LED_SRC_AT_RESET;
      led_sw_sh       = '0;
      repeat (16) @(posedge wb_clk);
      #DRV_DLY;
      wb_rst = 1'b0;

      // After reset
      check_val("ctrl_o", ctrl_o, '0);
      check_val("leds_o", leds_o, led_ref(LED_SRC_AT_RESET, '0, hw_status_i));
      check_val("int_o", int_o, 0);

      // New control register value visible one cycle after ack
      for (int i = 0; i < 12; i++) begin
         rng = xorshift(rng);
         case (rng[1:0])
            2'd0:    sa = SR_CLOCK;
            2'd1:    sa = SR_SERDES;
            2'd2:    sa = SR_ADC;
            default: sa = SR_PHY;
         endcase
         rng = xorshift(rng);
         setting_write(sa, rng);
         case (sa)
            SR_CLOCK:  clock_sh  = rng[4:0];
            SR_SERDES: serdes_sh = rng[3:0];
            SR_ADC:    adc_sh    = rng[3:0];
            default:   phy_sh    = rng[0];
         endcase
         check_val("ctrl_o", ctrl_o, ctrl_ref(clock_sh, serdes_sh, adc_sh, phy_sh));
      end

      // LED mux
      for (int i = 0; i < 6; i++) begin
         rng        = xorshift(rng);
         led_src_sh = rng[7:0];
         setting_write(SR_LED_SRC, rng);
         rng        = xorshift(rng);
         led_sw_sh  = rng[7:0];
         setting_write(SR_LED_SW, rng);
         rng         = xorshift(rng);
         hw_status_i = rng[3:0];
         idle_cycles(1);
         check_val("leds_o", leds_o, led_ref(led_src_sh, led_sw_sh, hw_status_i));
      end

      // Readback words
      word_read(REGION_READBACK, 3'd0, rd);
      check_val("compat number", rd, 32'd2);
      word_read(REGION_READBACK, 3'd2, rd);
      check_val("status word", rd, status_ref(sim_mode_i, clock_divider_i));
      word_read(REGION_READBACK, 3'd1, rd);
      word_read(REGION_READBACK, 3'd1, rd2);
      checks++;
      if (rd2 <= rd) begin
         errors++;
         $display("cycle counter did not increase, read %0d then %0d", rd, rd2);
      end

      // One-time timer into pic bit 0
      pic_write(3'd1, 32'hff);
      pic_write(3'd0, 32'h1);
      setting_write(SR_SIMTIMER, ONETIME_N);
      idle_cycles(ONETIME_N / 2);
      word_read(REGION_PIC, 3'd1, rd);
      check_val("pending[0] early", rd[0], 0);
      idle_cycles(ONETIME_N / 2 + 10);
      check_val("int_o", int_o, 1);
      word_read(REGION_PIC, 3'd1, rd);
      check_val("pending[0]", rd[0], 1);
      pic_write(3'd1, 32'h1);
      check_val("int_o", int_o, 0);
      word_read(REGION_PIC, 3'd1, rd);
      check_val("pending[0] cleared", rd[0], 0);
      // PHY interrupt pulse while masked
      phy_int_n_i = 1'b0;
      idle_cycles(2);
      phy_int_n_i = 1'b1;
      idle_cycles(2);
      word_read(REGION_PIC, 3'd1, rd);
      check_val("pending[2]", rd[2], 1);
      check_val("int_o", int_o, 0);

      // Periodic timer into pic bit 1
      pic_write(3'd1, 32'hff);
      pic_write(3'd0, 32'h2);
      setting_write(set_addr_t'(SR_SIMTIMER + 1), PERIOD_P);
      for (int i = 0; i < 3; i++) begin
         wait_pending(IRQ_PERIODIC, PERIOD_P + 10);
         check_val("int_o", int_o, 1);
         pic_write(3'd1, 32'h2);
      end
      // Zero period stops the pulses
      setting_write(set_addr_t'(SR_SIMTIMER + 1), 32'd0);
      pic_write(3'd1, 32'h2);
      idle_cycles(PERIOD_P + 10);
      word_read(REGION_PIC, 3'd1, rd);
      check_val("pending[1] after stop", rd[1], 0);
      check_val("int_o", int_o, 0);

      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: source/ctrl_reg_bank.sv
`timescale 1ns/100ps
// Setting registers for clock gen, SERDES, ADC and PHY control lines
// Also holds the software LED value and the per-bit LED source select

module ctrl_reg_bank
   import u2_ctrl_pkg::*;
(
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  set_bus_t    set_bus_i,
   input  hw_status_t  hw_status_i,
   output ctrl_lines_t ctrl_o,
   output led_t        leds_o
);

   logic [4:0] clock_r;
   logic [3:0] serdes_r;
   logic [3:0] adc_r;
   logic       phy_rst_r;
   led_t       led_sw_r;
   led_t       led_src_r;
   led_t       led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Setting registers, loaded on a strobe at their own address
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_r   <= '0;
         serdes_r  <= '0;
         adc_r     <= '0;
         // PHY held in reset until software releases it
         phy_rst_r <= PHY_RST_AT_RESET;
         led_sw_r  <= '0;
         led_src_r <= LED_SRC_AT_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            SR_CLOCK:   clock_r   <= set_bus_i.data[4:0];
            SR_SERDES:  serdes_r  <= set_bus_i.data[3:0];
            SR_ADC:     adc_r     <= set_bus_i.data[3:0];
            SR_LED_SW:  led_sw_r  <= set_bus_i.data[7:0];
            SR_PHY:     phy_rst_r <= set_bus_i.data[0];
            SR_LED_SRC: led_src_r <= set_bus_i.data[7:0];
            default:    ;
         endcase
      end
   end

   // Clock word, bit 4 is clock_ready
   always_comb begin
      ctrl_o.clock_ready = clock_r[4];
      ctrl_o.clk_en      = clock_r[3:2];
      ctrl_o.clk_sel     = clock_r[1:0];
      // SERDES word
      ctrl_o.ser_enable  = serdes_r[3];
      ctrl_o.ser_prbsen  = serdes_r[2];
      ctrl_o.ser_loopen  = serdes_r[1];
      ctrl_o.ser_rx_en   = serdes_r[0];
      // ADC word
      ctrl_o.adc_oe_a    = adc_r[3];
      ctrl_o.adc_on_a    = adc_r[2];
      ctrl_o.adc_oe_b    = adc_r[1];
      ctrl_o.adc_on_b    = adc_r[0];
      // Register holds the reset, pin is active low
      ctrl_o.phy_reset_n = ~phy_rst_r;
   end

   ////////////////////////////////////////////////////////////////////////////
   // LED mux
   // Hardware status on bits 4:1, rest unused
   assign led_hw = {3'b000, hw_status_i, 1'b0};
   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src_r & led_hw) | (~led_src_r & led_sw_r);

endmodule

// File: source/pic.sv
`timescale 1ns/100ps
// Interrupt controller with rising-edge latch, enable mask and write-one-to-clear pending
// Word 0 enable, word 1 pending, word 2 raw sources

module pic
   import u2_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       pic_wr_i,
   input  logic [2:0] rd_idx_i,
   input  wb_dat_t    dat_i,
   output wb_dat_t    dat_o,
   input  logic       onetime_int_i,
   input  logic       periodic_int_i,
   input  logic       phy_int_n_i,
   input  hw_status_t hw_status_i,
   output logic       int_o
);

   irq_vec_t irq_vec;
   irq_vec_t irq_d_r;
   irq_vec_t rise;
   irq_vec_t enable_r;
   irq_vec_t enable_nxt;
   irq_vec_t pending_r;
   irq_vec_t pending_nxt;

   // Source vector, PHY line is active low
   always_comb begin
      irq_vec                 = '0;
      irq_vec[IRQ_ONETIME]    = onetime_int_i;
      irq_vec[IRQ_PERIODIC]   = periodic_int_i;
      irq_vec[IRQ_PHY]        = ~phy_int_n_i;
      irq_vec[IRQ_CLK_STATUS] = hw_status_i.clk_status;
      irq_vec[IRQ_LINK]       = hw_status_i.serdes_link_up;
   end

   assign rise = irq_vec & ~irq_d_r;

   // New edges win over a clear in the same cycle
   always_comb begin
      enable_nxt  = enable_r;
      pending_nxt = pending_r | rise;
      if (pic_wr_i && (rd_idx_i == 3'd0)) begin
         enable_nxt = dat_i[7:0];
      end
      if (pic_wr_i && (rd_idx_i == 3'd1)) begin
         pending_nxt = (pending_r & ~dat_i[7:0]) | rise;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         irq_d_r   <= '0;
         enable_r  <= '0;
         pending_r <= '0;
         int_o     <= 1'b0;
      end else begin
         irq_d_r   <= irq_vec;
         enable_r  <= enable_nxt;
         pending_r <= pending_nxt;
         // Registered from next state so it tracks the masked pending bits
         int_o     <= |(pending_nxt & enable_nxt);
      end
   end

   always_comb begin
      case (rd_idx_i)
         3'd0:    dat_o = {24'd0, enable_r};
         3'd1:    dat_o = {24'd0, pending_r};
         3'd2:    dat_o = {24'd0, irq_vec};
         default: dat_o = '0;
      endcase
   end

   // No interrupt without an enabled pending bit
   int_masked_a: assert property (@(posedge wb_clk) disable iff (wb_rst)
      ((pending_r & enable_r) == '0) |-> !int_o);

endmodule

// File: source/readback_regs.sv
`timescale 1ns/100ps
// Read-only status words for the readback region
// Word 0 compat number, word 1 cycle count, word 2 sim mode and clock divider

module readback_regs
   import u2_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic [2:0] rd_idx_i,
   input  logic       sim_mode_i,
   input  logic [3:0] clock_divider_i,
   output wb_dat_t    dat_o
);

   wb_dat_t cycle_cnt_r;

   // Free-running, wraps
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_cnt_r <= '0;
      end else begin
         cycle_cnt_r <= cycle_cnt_r + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Word select, unused indices read zero
   always_comb begin
      case (rd_idx_i)
         3'd0:    dat_o = COMPAT_NUM;
         3'd1:    dat_o = cycle_cnt_r;
         // Sim flag on top, divider in the low nibble
         3'd2:    dat_o = {sim_mode_i, 27'd0, clock_divider_i};
         default: dat_o = '0;
      endcase
   end

endmodule

// File: source/simple_timer.sv
`timescale 1ns/100ps
// One-time and periodic interrupt timers, counts loaded over the settings bus
// Writing zero to either count stops that timer

module simple_timer
   import u2_ctrl_pkg::*;
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  set_bus_t set_bus_i,
   output logic     onetime_int_o,
   output logic     periodic_int_o
);

   wb_dat_t onetime_ctr_r;
   wb_dat_t period_r;
   wb_dat_t periodic_ctr_r;
   logic    load_onetime;
   logic    load_periodic;

   assign load_onetime  = set_bus_i.stb && (set_bus_i.addr == SR_SIMTIMER);
   assign load_periodic = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(SR_SIMTIMER + 1));

   // One-time down-counter, fires N edges after the load
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         onetime_ctr_r <= '0;
         onetime_int_o <= 1'b0;
      end else begin
         onetime_int_o <= !load_onetime && (onetime_ctr_r == 32'd1);
         if (load_onetime) begin
            onetime_ctr_r <= set_bus_i.data;
         end else if (onetime_ctr_r != '0) begin
            onetime_ctr_r <= onetime_ctr_r - 1'b1;
         end
      end
   end

   // Periodic counter, reloads from the period register on expiry
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         period_r       <= '0;
         periodic_ctr_r <= '0;
         periodic_int_o <= 1'b0;
      end else if (load_periodic) begin
         period_r       <= set_bus_i.data;
         periodic_ctr_r <= set_bus_i.data;
         periodic_int_o <= 1'b0;
      end else begin
         periodic_int_o <= (period_r != '0) && (periodic_ctr_r == 32'd1);
         if (period_r != '0) begin
            if (periodic_ctr_r == 32'd1) begin
               periodic_ctr_r <= period_r;
            end else begin
               periodic_ctr_r <= periodic_ctr_r - 1'b1;
            end
         end
      end
   end

   // Both interrupts are single-cycle pulses into the pic edge detect
   onetime_pulse_a: assert property (@(posedge wb_clk) disable iff (wb_rst)
      onetime_int_o |=> !onetime_int_o);
   periodic_pulse_a: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (periodic_int_o && (period_r > 32'd1)) |=> !periodic_int_o);

endmodule

// File: source/u2_ctrl_core.sv
`timescale 1ns/100ps
// Top of the housekeeping control core
// Wishbone slave in front of settings, timer, pic and readback blocks

module u2_ctrl_core
   import u2_ctrl_pkg::*;
(
   input  logic        wb_clk,
   input  logic        wb_rst,
   // Wishbone slave
   input  wb_adr_t     wb_adr_i,
   input  wb_dat_t     wb_dat_i,
   input  logic        wb_we_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   output logic        wb_ack_o,
   output wb_dat_t     wb_dat_o,
   // Board status and control
   input  hw_status_t  hw_status_i,
   input  logic        phy_int_n_i,
   input  logic        sim_mode_i,
   input  logic [3:0]  clock_divider_i,
   output ctrl_lines_t ctrl_o,
   output led_t        leds_o,
   output logic        int_o
);

   set_bus_t   set_bus;
   logic       pic_wr;
   logic [2:0] rd_idx;
   wb_dat_t    pic_dat;
   wb_dat_t    rb_dat;
   logic       onetime_int;
   logic       periodic_int;

   wb_bus_bridge i_bridge (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .wb_adr_i  (wb_adr_i),
      .wb_dat_i  (wb_dat_i),
      .wb_we_i   (wb_we_i),
      .wb_stb_i  (wb_stb_i),
      .wb_cyc_i  (wb_cyc_i),
      .wb_ack_o  (wb_ack_o),
      .wb_dat_o  (wb_dat_o),
      .set_bus_o (set_bus),
      .pic_wr_o  (pic_wr),
      .rd_idx_o  (rd_idx),
      .pic_dat_i (pic_dat),
      .rb_dat_i  (rb_dat)
   );

   ctrl_reg_bank i_regs (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .set_bus_i   (set_bus),
      .hw_status_i (hw_status_i),
      .ctrl_o      (ctrl_o),
      .leds_o      (leds_o)
   );

   simple_timer i_timer (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .set_bus_i      (set_bus),
      .onetime_int_o  (onetime_int),
      .periodic_int_o (periodic_int)
   );

   // Pic write data comes from the bridge's captured write word
   pic i_pic (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .pic_wr_i       (pic_wr),
      .rd_idx_i       (rd_idx),
      .dat_i          (set_bus.data),
      .dat_o          (pic_dat),
      .onetime_int_i  (onetime_int),
      .periodic_int_i (periodic_int),
      .phy_int_n_i    (phy_int_n_i),
      .hw_status_i    (hw_status_i),
      .int_o          (int_o)
   );

   readback_regs i_readback (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .rd_idx_i        (rd_idx),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .dat_o           (rb_dat)
   );

endmodule

// File: source/u2_ctrl_pkg.sv
// Shared types, address map and setting addresses for the housekeeping control core
// Import with a wildcard in each module header that needs it

package u2_ctrl_pkg;

   // Bus and payload widths
   typedef logic [15:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [7:0]  set_addr_t;
   typedef logic [7:0]  irq_vec_t;
   typedef logic [7:0]  led_t;

   // Regions live in byte address bits 11:10, code 3 is unmapped
   localparam logic [1:0] REGION_SETTINGS = 2'd0;
   localparam logic [1:0] REGION_PIC      = 2'd1;
   localparam logic [1:0] REGION_READBACK = 2'd2;

   // Setting register addresses
   localparam set_addr_t SR_CLOCK    = 8'd0;
   localparam set_addr_t SR_SERDES   = 8'd1;
   localparam set_addr_t SR_ADC      = 8'd2;
   localparam set_addr_t SR_LED_SW   = 8'd3;
   localparam set_addr_t SR_PHY      = 8'd4;
   localparam set_addr_t SR_LED_SRC  = 8'd8;
   // One-time count here, periodic count at the next address
   localparam set_addr_t SR_SIMTIMER = 8'd198;

   // Reset values
   localparam led_t    LED_SRC_AT_RESET = 8'b0001_1110;
   localparam logic    PHY_RST_AT_RESET = 1'b1;
   // Bump when the register map changes
   localparam wb_dat_t COMPAT_NUM       = 32'd2;

   // Interrupt source bit positions
   localparam int IRQ_ONETIME    = 0;
   localparam int IRQ_PERIODIC   = 1;
   localparam int IRQ_PHY        = 2;
   localparam int IRQ_CLK_STATUS = 3;
   localparam int IRQ_LINK       = 4;

   typedef enum logic {BUS_IDLE, BUS_ACK} bus_state_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      wb_dat_t   data;
   } set_bus_t;

   // Clock gen, SERDES, ADC and PHY control lines
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
   } ctrl_lines_t;

   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic serdes_link_up;
   } hw_status_t;

endpackage

// File: source/wb_bus_bridge.sv
`timescale 1ns/100ps
// Wishbone slave front end for the control core
// Decodes the region, issues setting strobes and pic writes, returns read data with ack

module wb_bus_bridge
   import u2_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  wb_adr_t    wb_adr_i,
   input  wb_dat_t    wb_dat_i,
   input  logic       wb_we_i,
   input  logic       wb_stb_i,
   input  logic       wb_cyc_i,
   output logic       wb_ack_o,
   output wb_dat_t    wb_dat_o,
   output set_bus_t   set_bus_o,
   output logic       pic_wr_o,
   output logic [2:0] rd_idx_o,
   input  wb_dat_t    pic_dat_i,
   input  wb_dat_t    rb_dat_i
);

   bus_state_t state_r;
   logic [1:0] region;
   logic       req;
   wb_dat_t    rd_word;
   logic       set_stb_r;
   set_addr_t  set_addr_r;
   wb_dat_t    set_data_r;
   logic       pic_wr_r;

   // Region code and word index straight from the held address
   assign region   = wb_adr_i[11:10];
   assign rd_idx_o = wb_adr_i[4:2];
   // New request only taken while idle
   assign req      = wb_stb_i & wb_cyc_i & (state_r == BUS_IDLE);

   // Read source select, settings and unmapped read zero
   always_comb begin
      case (region)
         REGION_PIC:      rd_word = pic_dat_i;
         REGION_READBACK: rd_word = rb_dat_i;
         default:         rd_word = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Request FSM, one cycle in ACK per access
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state_r   <= BUS_IDLE;
         set_stb_r <= 1'b0;
         pic_wr_r  <= 1'b0;
      end else begin
         set_stb_r <= req & wb_we_i & (region == REGION_SETTINGS);
         pic_wr_r  <= req & wb_we_i & (region == REGION_PIC);
         case (state_r)
            BUS_IDLE: begin
               if (req) begin
                  state_r <= BUS_ACK;
               end
            end
            default: state_r <= BUS_IDLE;
         endcase
      end
   end

   // Payload captured on accept, held through the ack cycle
   always_ff @(posedge wb_clk) begin
      if (req) begin
         set_addr_r <= wb_adr_i[9:2];
         set_data_r <= wb_dat_i;
         wb_dat_o   <= rd_word;
      end
   end

   assign wb_ack_o  = (state_r == BUS_ACK);
   assign pic_wr_o  = pic_wr_r;
   assign set_bus_o = '{stb: set_stb_r, addr: set_addr_r, data: set_data_r};

   // Ack is a single-cycle pulse per access
   ack_single_a: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack_o |=> !wb_ack_o);
   // Setting strobe only rides along with ack
   set_stb_ack_a: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_bus_o.stb |-> wb_ack_o);

endmodule

// File: u2_ctrl_core.f
source/u2_ctrl_pkg.sv
source/wb_bus_bridge.sv
source/ctrl_reg_bank.sv
source/simple_timer.sv
source/pic.sv
source/readback_regs.sv
source/u2_ctrl_core.sv
dv/u2_ctrl_tb.sv
